// ==== include/inst_defs.svh ====
`ifndef INST_DEFS_SVH
`define INST_DEFS_SVH

// bit positions of the RV32I instruction fields

`define REG_RANGE      6:0    // opcode field
`define RD_RANGE       11:7
`define FUNCT_3_RANGE  14:12
`define RS1_RANGE      19:15
`define RS2_RANGE      24:20
`define FUNCT_7_RANGE  31:25

// S-type keeps imm[4:0] where rd would be, imm[11:5] where funct7 would be
// B-type and J-type scramble the same spots, see imm_gen

`endif

// ==== rtl/riscv_pkg.sv ====
package riscv_pkg;

    // RV32I major opcodes, bits 6:0
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        AUIPC  = 7'b0010111,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10    // lui, result is the immediate
    } alu_op_e;

    // writeback source
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2    // link address for jal/jalr
    } wb_sel_e;

    // same encoding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    // funct7 of sub, sra and srai
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    // funct3 of the register and immediate ALU ops
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

endpackage

// ==== rtl/decode_ctrl_if.sv ====
`timescale 1ns/100ps

interface decode_ctrl_if;

    logic                  rf_write_enable;
    logic                  pc_rs1_sel;       // 1 = pc as operand a
    logic                  imm_rs2_sel;      // 1 = immediate as operand b
    logic                  mem_read_enable;
    logic                  mem_write_enable;
    riscv_pkg::mem_size_e  mem_size;
    logic                  load_unsigned;    // lbu, lhu
    logic                  jump;
    logic                  branch;
    riscv_pkg::alu_op_e    alu_op;
    riscv_pkg::wb_sel_e    wb_sel;
    logic                  illegal;

    // control unit side
    modport ctrl (
        output rf_write_enable, pc_rs1_sel, imm_rs2_sel, mem_read_enable,
        output mem_write_enable, mem_size, load_unsigned, jump, branch,
        output alu_op, wb_sel, illegal
    );

    // pipeline register side
    modport pipe (
        input rf_write_enable, pc_rs1_sel, imm_rs2_sel, mem_read_enable,
        input mem_write_enable, mem_size, load_unsigned, jump, branch,
        input alu_op, wb_sel, illegal
    );

endinterface

// ==== rtl/control_unit.sv ====
`timescale 1ns/100ps

`include "inst_defs.svh"

module control_unit (
    input  logic [`REG_RANGE] opcode,
    input  logic [2:0]        funct3,
    input  logic [6:0]        funct7,
    decode_ctrl_if.ctrl       ctrl
);

    logic               funct7_zero;
    logic               funct7_alt;
    riscv_pkg::alu_op_e alu_f3;    // alu op picked by funct3 alone

    assign funct7_zero = (funct7 == 7'b0000000);
    assign funct7_alt  = (funct7 == riscv_pkg::FUNCT7_ALT);

    // shared by OP and OP-IMM, sub is added in the OP branch only
    always_comb begin
        case (funct3)
            riscv_pkg::F3_ADD_SUB: alu_f3 = riscv_pkg::ALU_ADD;
            riscv_pkg::F3_SLL:     alu_f3 = riscv_pkg::ALU_SLL;
            riscv_pkg::F3_SLT:     alu_f3 = riscv_pkg::ALU_SLT;
            riscv_pkg::F3_SLTU:    alu_f3 = riscv_pkg::ALU_SLTU;
            riscv_pkg::F3_XOR:     alu_f3 = riscv_pkg::ALU_XOR;
            riscv_pkg::F3_SRL_SRA: alu_f3 = funct7_alt ? riscv_pkg::ALU_SRA : riscv_pkg::ALU_SRL;
            riscv_pkg::F3_OR:      alu_f3 = riscv_pkg::ALU_OR;
            default:               alu_f3 = riscv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        // safe defaults, nothing written, nothing accessed
        ctrl.rf_write_enable  = 1'b0;
        ctrl.pc_rs1_sel       = 1'b0;
        ctrl.imm_rs2_sel      = 1'b0;
        ctrl.mem_read_enable  = 1'b0;
        ctrl.mem_write_enable = 1'b0;
        ctrl.mem_size         = riscv_pkg::MEM_WORD;
        ctrl.load_unsigned    = 1'b0;
        ctrl.jump             = 1'b0;
        ctrl.branch           = 1'b0;
        ctrl.alu_op           = riscv_pkg::ALU_ADD;
        ctrl.wb_sel           = riscv_pkg::WB_ALU;
        ctrl.illegal          = 1'b0;

        case (opcode)
            riscv_pkg::OP_IMM: begin
                ctrl.rf_write_enable = 1'b1;
                ctrl.imm_rs2_sel     = 1'b1;
                ctrl.alu_op          = alu_f3;    // addi never becomes sub
                // shift amounts leave funct7 as an opcode extension
                if (funct3 == riscv_pkg::F3_SLL && !funct7_zero)
                    ctrl.illegal = 1'b1;
                if (funct3 == riscv_pkg::F3_SRL_SRA && !(funct7_zero || funct7_alt))
                    ctrl.illegal = 1'b1;
            end
            riscv_pkg::OP: begin
                ctrl.rf_write_enable = 1'b1;
                if (funct3 == riscv_pkg::F3_ADD_SUB && funct7_alt)
                    ctrl.alu_op = riscv_pkg::ALU_SUB;
                else
                    ctrl.alu_op = alu_f3;
                // alt form only for sub and sra, funct7 = 1 (M ext) falls here too
                if (!funct7_zero && !(funct7_alt && (funct3 == riscv_pkg::F3_ADD_SUB ||
                                                     funct3 == riscv_pkg::F3_SRL_SRA)))
                    ctrl.illegal = 1'b1;
            end
            riscv_pkg::LOAD: begin
                ctrl.rf_write_enable = 1'b1;
                ctrl.imm_rs2_sel     = 1'b1;    // rs1 + offset
                ctrl.mem_read_enable = 1'b1;
                ctrl.wb_sel          = riscv_pkg::WB_MEM;
                ctrl.mem_size        = riscv_pkg::mem_size_e'(funct3[1:0]);
                ctrl.load_unsigned   = funct3[2];
                // lb lh lw lbu lhu only
                if (funct3 == 3'b011 || funct3[2:1] == 2'b11)
                    ctrl.illegal = 1'b1;
            end
            riscv_pkg::STORE: begin
                ctrl.imm_rs2_sel      = 1'b1;
                ctrl.mem_write_enable = 1'b1;
                ctrl.mem_size         = riscv_pkg::mem_size_e'(funct3[1:0]);
                if (funct3[2] || funct3[1:0] == 2'b11)
                    ctrl.illegal = 1'b1;
            end
            riscv_pkg::BRANCH: begin
                ctrl.branch = 1'b1;
                // compare of rs1 and rs2 in the alu
                case (funct3[2:1])
                    2'b00:   ctrl.alu_op = riscv_pkg::ALU_SUB;     // beq, bne
                    2'b10:   ctrl.alu_op = riscv_pkg::ALU_SLT;     // blt, bge
                    2'b11:   ctrl.alu_op = riscv_pkg::ALU_SLTU;    // bltu, bgeu
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            riscv_pkg::LUI: begin
                ctrl.rf_write_enable = 1'b1;
                ctrl.imm_rs2_sel     = 1'b1;
                ctrl.alu_op          = riscv_pkg::ALU_PASS_B;
            end
            riscv_pkg::AUIPC: begin
                ctrl.rf_write_enable = 1'b1;
                ctrl.pc_rs1_sel      = 1'b1;    // pc + upper imm
                ctrl.imm_rs2_sel     = 1'b1;
            end
            riscv_pkg::JAL: begin
                ctrl.rf_write_enable = 1'b1;
                ctrl.pc_rs1_sel      = 1'b1;    // target is pc relative
                ctrl.imm_rs2_sel     = 1'b1;
                ctrl.jump            = 1'b1;
                ctrl.wb_sel          = riscv_pkg::WB_PC4;
            end
            riscv_pkg::JALR: begin
                ctrl.rf_write_enable = 1'b1;
                ctrl.imm_rs2_sel     = 1'b1;    // rs1 + offset
                ctrl.jump            = 1'b1;
                ctrl.wb_sel          = riscv_pkg::WB_PC4;
                if (funct3 != 3'b000)
                    ctrl.illegal = 1'b1;
            end
            default: ctrl.illegal = 1'b1;    // fence, system and the rest
        endcase
    end

endmodule

// ==== rtl/imm_gen.sv ====
`timescale 1ns/100ps

`include "inst_defs.svh"

module imm_gen (
    input  logic [31:0] instr,
    output logic [31:0] imm
);

    typedef enum logic [2:0] {
        FMT_NONE,    // OP and unknown opcodes
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J
    } fmt_e;

    fmt_e fmt;
    logic sign;

    assign sign = instr[31];    // every format keeps its sign here

    always_comb begin
        case (instr[`REG_RANGE])
            riscv_pkg::OP_IMM,
            riscv_pkg::LOAD,
            riscv_pkg::JALR:   fmt = FMT_I;
            riscv_pkg::STORE:  fmt = FMT_S;
            riscv_pkg::BRANCH: fmt = FMT_B;
            riscv_pkg::LUI,
            riscv_pkg::AUIPC:  fmt = FMT_U;
            riscv_pkg::JAL:    fmt = FMT_J;
            default:           fmt = FMT_NONE;
        endcase
    end

    always_comb begin
        case (fmt)
            FMT_I:   imm = {{20{sign}}, instr[31:20]};
            FMT_S:   imm = {{20{sign}}, instr[`FUNCT_7_RANGE], instr[`RD_RANGE]};
            FMT_B:   imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            FMT_U:   imm = {instr[31:12], 12'h000};
            FMT_J:   imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = 32'h0000_0000;
        endcase
    end

endmodule

// ==== rtl/id_ex_register.sv ====
`timescale 1ns/100ps

`include "inst_defs.svh"

module id_ex_register (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instr_valid,
    input  logic                 flush,
    input  logic [31:0]          instr,
    input  logic [31:0]          pc,
    input  logic [31:0]          imm,
    decode_ctrl_if.pipe          ctrl,
    output logic                 ex_valid,
    output logic [31:0]          ex_pc,
    output logic [31:0]          ex_imm,
    output logic [4:0]           ex_rd,
    output logic [4:0]           ex_rs1,
    output logic [4:0]           ex_rs2,
    output logic [2:0]           ex_funct3,
    output logic                 ex_rf_write_enable,
    output logic                 ex_pc_rs1_sel,
    output logic                 ex_imm_rs2_sel,
    output logic                 ex_mem_read_enable,
    output logic                 ex_mem_write_enable,
    output riscv_pkg::mem_size_e ex_mem_size,
    output logic                 ex_load_unsigned,
    output logic                 ex_jump,
    output logic                 ex_branch,
    output riscv_pkg::alu_op_e   ex_alu_op,
    output riscv_pkg::wb_sel_e   ex_wb_sel,
    output logic                 ex_illegal
);

    logic accept;
    logic allow;    // low for an illegal instruction

    assign accept = instr_valid && !flush;    // flush wins over the strobe
    assign allow  = !ctrl.illegal;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid            <= 1'b0;
            ex_rf_write_enable  <= 1'b0;
            ex_mem_read_enable  <= 1'b0;
            ex_mem_write_enable <= 1'b0;
            ex_jump             <= 1'b0;
            ex_branch           <= 1'b0;
            ex_illegal          <= 1'b0;
        end else begin
            ex_valid <= accept;    // drops on a gap or a flush
            if (accept) begin
                // side effects masked so a bad instruction does nothing
                ex_rf_write_enable  <= ctrl.rf_write_enable && allow;
                ex_mem_read_enable  <= ctrl.mem_read_enable && allow;
                ex_mem_write_enable <= ctrl.mem_write_enable && allow;
                ex_jump             <= ctrl.jump && allow;
                ex_branch           <= ctrl.branch && allow;
                ex_illegal          <= ctrl.illegal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_pc            <= pc;
            ex_imm           <= imm;
            ex_rd            <= instr[`RD_RANGE];
            ex_rs1           <= instr[`RS1_RANGE];
            ex_rs2           <= instr[`RS2_RANGE];
            ex_funct3        <= instr[`FUNCT_3_RANGE];    // branch and load/store variant
            ex_pc_rs1_sel    <= ctrl.pc_rs1_sel;
            ex_imm_rs2_sel   <= ctrl.imm_rs2_sel;
            ex_mem_size      <= ctrl.mem_size;
            ex_load_unsigned <= ctrl.load_unsigned;
            ex_alu_op        <= ctrl.alu_op;
            ex_wb_sel        <= ctrl.wb_sel;
        end
    end

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/100ps

`include "inst_defs.svh"

module decode_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instr_valid,
    input  logic [31:0]          instr,
    input  logic [31:0]          pc,
    input  logic                 flush,
    output logic                 ex_valid,
    output logic [31:0]          ex_pc,
    output logic [31:0]          ex_imm,
    output logic [4:0]           ex_rd,
    output logic [4:0]           ex_rs1,
    output logic [4:0]           ex_rs2,
    output logic [2:0]           ex_funct3,
    output logic                 ex_rf_write_enable,
    output logic                 ex_pc_rs1_sel,
    output logic                 ex_imm_rs2_sel,
    output logic                 ex_mem_read_enable,
    output logic                 ex_mem_write_enable,
    output riscv_pkg::mem_size_e ex_mem_size,
    output logic                 ex_load_unsigned,
    output logic                 ex_jump,
    output logic                 ex_branch,
    output riscv_pkg::alu_op_e   ex_alu_op,
    output riscv_pkg::wb_sel_e   ex_wb_sel,
    output logic                 ex_illegal
);

    logic [31:0] imm;

    decode_ctrl_if ctrl_bus ();

    // control and immediate decode run side by side on the same word
    control_unit i_control_unit (
        .opcode (instr[`REG_RANGE]),
        .funct3 (instr[`FUNCT_3_RANGE]),
        .funct7 (instr[`FUNCT_7_RANGE]),
        .ctrl   (ctrl_bus.ctrl)
    );

    imm_gen i_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    id_ex_register i_id_ex_register (
        .clk                 (clk),
        .reset               (reset),
        .instr_valid         (instr_valid),
        .flush               (flush),
        .instr               (instr),
        .pc                  (pc),
        .imm                 (imm),
        .ctrl                (ctrl_bus.pipe),
        .ex_valid            (ex_valid),
        .ex_pc               (ex_pc),
        .ex_imm              (ex_imm),
        .ex_rd               (ex_rd),
        .ex_rs1              (ex_rs1),
        .ex_rs2              (ex_rs2),
        .ex_funct3           (ex_funct3),
        .ex_rf_write_enable  (ex_rf_write_enable),
        .ex_pc_rs1_sel       (ex_pc_rs1_sel),
        .ex_imm_rs2_sel      (ex_imm_rs2_sel),
        .ex_mem_read_enable  (ex_mem_read_enable),
        .ex_mem_write_enable (ex_mem_write_enable),
        .ex_mem_size         (ex_mem_size),
        .ex_load_unsigned    (ex_load_unsigned),
        .ex_jump             (ex_jump),
        .ex_branch           (ex_branch),
        .ex_alu_op           (ex_alu_op),
        .ex_wb_sel           (ex_wb_sel),
        .ex_illegal          (ex_illegal)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;    // 20 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #2 reset = 1'b0;    // released just after the fourth edge
    end

endmodule

// ==== testbench/decode_stage_asserts.sv ====
`timescale 1ns/100ps

module decode_stage_asserts (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic ex_valid,
    input logic ex_illegal,
    input logic ex_rf_write_enable,
    input logic ex_mem_write_enable,
    input logic ex_jump
);

    int unsigned error_count;    // read by the testbench top

    initial error_count = 0;

    valid_after_reset: assert property (@(posedge clk) reset |=> !ex_valid)
        else begin
            error_count++;
            $error("ex_valid set in the cycle after reset");
        end

    valid_after_flush: assert property (@(posedge clk) flush |=> !ex_valid)
        else begin
            error_count++;
            $error("ex_valid set in the cycle after a flush");
        end

    // an illegal instruction must leave no trace
    illegal_no_effect: assert property (@(posedge clk) disable iff (reset)
        ex_illegal |-> !(ex_rf_write_enable || ex_mem_write_enable || ex_jump))
        else begin
            error_count++;
            $error("side effect enabled for an illegal instruction");
        end

    store_no_writeback: assert property (@(posedge clk) disable iff (reset)
        !(ex_mem_write_enable && ex_rf_write_enable))
        else begin
            error_count++;
            $error("memory write and register write both enabled");
        end

endmodule

bind id_ex_register decode_stage_asserts i_decode_stage_asserts (
    .clk                 (clk),
    .reset               (reset),
    .flush               (flush),
    .ex_valid            (ex_valid),
    .ex_illegal          (ex_illegal),
    .ex_rf_write_enable  (ex_rf_write_enable),
    .ex_mem_write_enable (ex_mem_write_enable),
    .ex_jump             (ex_jump)
);

// ==== testbench/tb_decode_stage.sv ====
`timescale 1ns/100ps

module tb_decode_stage;

    localparam int NUM_LEGAL   = 300;
    localparam int NUM_IMM     = 8;    // rounds over seven opcodes with the sign bit clear and set
    localparam int NUM_ILLEGAL = 90;
    localparam int NUM_ISSUED  = NUM_LEGAL + NUM_IMM * 14 + NUM_ILLEGAL + 10;

    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic        rf_we;
        logic        pc_sel;
        logic        imm_sel;
        logic        mem_rd;
        logic        mem_we;
        logic [1:0]  mem_size;
        logic        load_uns;
        logic        jump;
        logic        branch;
        logic [3:0]  alu_op;
        logic [1:0]  wb_sel;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
    } expect_t;

    logic                 clk;
    logic                 reset;
    logic                 instr_valid;
    logic [31:0]          instr;
    logic [31:0]          pc;
    logic                 flush;
    logic                 ex_valid;
    logic [31:0]          ex_pc;
    logic [31:0]          ex_imm;
    logic [4:0]           ex_rd;
    logic [4:0]           ex_rs1;
    logic [4:0]           ex_rs2;
    logic [2:0]           ex_funct3;
    logic                 ex_rf_write_enable;
    logic                 ex_pc_rs1_sel;
    logic                 ex_imm_rs2_sel;
    logic                 ex_mem_read_enable;
    logic                 ex_mem_write_enable;
    riscv_pkg::mem_size_e ex_mem_size;
    logic                 ex_load_unsigned;
    logic                 ex_jump;
    logic                 ex_branch;
    riscv_pkg::alu_op_e   ex_alu_op;
    riscv_pkg::wb_sel_e   ex_wb_sel;
    logic                 ex_illegal;

    expect_t pending;         // result due at the next edge
    string   pending_name;
    bit      pending_live;

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    decode_stage i_dut (.*);

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "run stopped at the first error");
        end
    endtask

    function automatic logic [3:0] alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return riscv_pkg::ALU_ADD;
            3'd1:    return riscv_pkg::ALU_SLL;
            3'd2:    return riscv_pkg::ALU_SLT;
            3'd3:    return riscv_pkg::ALU_SLTU;
            3'd4:    return riscv_pkg::ALU_XOR;
            3'd5:    return alt ? riscv_pkg::ALU_SRA : riscv_pkg::ALU_SRL;
            3'd6:    return riscv_pkg::ALU_OR;
            default: return riscv_pkg::ALU_AND;
        endcase
    endfunction

    // reference decode straight from the RV32I encoding tables
    function automatic expect_t decode_model(input logic [31:0] ins, input logic [31:0] p);
        expect_t    e;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       alt;
        f3 = ins[14:12];
        f7 = ins[31:25];
        alt = (f7 == riscv_pkg::FUNCT7_ALT);
        e = '0;
        e.mem_size = riscv_pkg::MEM_WORD;
        e.alu_op = riscv_pkg::ALU_ADD;
        e.wb_sel = riscv_pkg::WB_ALU;
        e.pc = p;
        e.rd = ins[11:7];
        e.rs1 = ins[19:15];
        e.rs2 = ins[24:20];
        e.funct3 = f3;
        case (ins[6:0])
            riscv_pkg::OP_IMM: begin
                e.rf_we = 1'b1;
                e.imm_sel = 1'b1;
                e.alu_op = alu_from_funct3(f3, alt);
                e.illegal = (f3 == 3'd1 && f7 != 7'd0) || (f3 == 3'd5 && f7 != 7'd0 && !alt);
                e.imm = 32'($signed(ins[31:20]));
            end
            riscv_pkg::OP: begin
                e.rf_we = 1'b1;
                e.alu_op = (f3 == 3'd0 && alt) ? riscv_pkg::ALU_SUB : alu_from_funct3(f3, alt);
                e.illegal = !(f7 == 7'd0 || (alt && (f3 == 3'd0 || f3 == 3'd5)));
            end
            riscv_pkg::LOAD: begin
                e.rf_we = 1'b1;
                e.imm_sel = 1'b1;
                e.mem_rd = 1'b1;
                e.wb_sel = riscv_pkg::WB_MEM;
                e.mem_size = f3[1:0];
                e.load_uns = f3[2];
                e.illegal = !(f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
                e.imm = 32'($signed(ins[31:20]));
            end
            riscv_pkg::STORE: begin
                e.imm_sel = 1'b1;
                e.mem_we = 1'b1;
                e.mem_size = f3[1:0];
                e.illegal = (f3 > 3'd2);
                e.imm = 32'($signed({ins[31:25], ins[11:7]}));
            end
            riscv_pkg::BRANCH: begin
                e.branch = 1'b1;
                case (f3)
                    3'd0, 3'd1: e.alu_op = riscv_pkg::ALU_SUB;
                    3'd4, 3'd5: e.alu_op = riscv_pkg::ALU_SLT;
                    3'd6, 3'd7: e.alu_op = riscv_pkg::ALU_SLTU;
                    default:    e.illegal = 1'b1;
                endcase
                e.imm = 32'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
            end
            riscv_pkg::LUI, riscv_pkg::AUIPC: begin
                e.rf_we = 1'b1;
                e.imm_sel = 1'b1;
                e.pc_sel = (ins[6:0] == riscv_pkg::AUIPC);
                if (ins[6:0] == riscv_pkg::LUI)
                    e.alu_op = riscv_pkg::ALU_PASS_B;
                e.imm = {ins[31:12], 12'd0};
            end
            riscv_pkg::JAL, riscv_pkg::JALR: begin
                e.rf_we = 1'b1;
                e.imm_sel = 1'b1;
                e.jump = 1'b1;
                e.wb_sel = riscv_pkg::WB_PC4;
                if (ins[6:0] == riscv_pkg::JAL) begin
                    e.pc_sel = 1'b1;
                    e.imm = 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
                end else begin
                    e.illegal = (f3 != 3'd0);
                    e.imm = 32'($signed(ins[31:20]));
                end
            end
            default: e.illegal = 1'b1;
        endcase
        if (e.illegal) begin
            e.rf_we = 1'b0;
            e.mem_rd = 1'b0;
            e.mem_we = 1'b0;
            e.jump = 1'b0;
            e.branch = 1'b0;
        end
        return e;
    endfunction

    function automatic bit known_opcode(input logic [6:0] op);
        return op inside {riscv_pkg::OP_IMM, riscv_pkg::OP, riscv_pkg::LOAD, riscv_pkg::STORE,
                          riscv_pkg::BRANCH, riscv_pkg::LUI, riscv_pkg::AUIPC,
                          riscv_pkg::JAL, riscv_pkg::JALR};
    endfunction

    // k picks the opcode from 0 OP_IMM to 8 JALR
    function automatic logic [31:0] legal_instr(input int unsigned k);
        logic [31:0] ins;
        logic        coin;
        ins = $urandom;
        coin = $urandom % 2;
        case (k % 9)
            0: begin
                ins[6:0] = riscv_pkg::OP_IMM;
                if (ins[14:12] == 3'd1 || ins[14:12] == 3'd5)    // shifts
                    ins[31:25] = coin ? riscv_pkg::FUNCT7_ALT : 7'd0;
                if (ins[14:12] == 3'd1)
                    ins[31:25] = 7'd0;
            end
            1: begin
                ins[6:0] = riscv_pkg::OP;
                ins[31:25] = (coin && (ins[14:12] == 3'd0 || ins[14:12] == 3'd5)) ?
                             riscv_pkg::FUNCT7_ALT : 7'd0;
            end
            2: begin
                ins[6:0] = riscv_pkg::LOAD;
                ins[14:12] = (ins[14:12] == 3'd3 || ins[14:12] > 3'd5) ? 3'd4 : ins[14:12];
            end
            3: begin
                ins[6:0] = riscv_pkg::STORE;
                ins[14:12] = 3'($urandom % 3);
            end
            4: begin
                ins[6:0] = riscv_pkg::BRANCH;
                ins[13] = ins[14] ? ins[13] : 1'b0;    // funct3 2 and 3 are reserved
            end
            5: ins[6:0] = riscv_pkg::LUI;
            6: ins[6:0] = riscv_pkg::AUIPC;
            7: ins[6:0] = riscv_pkg::JAL;
            default: begin
                ins[6:0] = riscv_pkg::JALR;
                ins[14:12] = 3'd0;
            end
        endcase
        return ins;
    endfunction

    function automatic logic [31:0] illegal_instr(input int unsigned k);
        logic [31:0] ins;
        logic [6:0]  op;
        ins = $urandom;
        case (k % 3)
            0: begin
                do op = 7'($urandom); while (known_opcode(op));
                ins[6:0] = op;
            end
            1: begin
                ins[6:0] = riscv_pkg::OP;
                ins[31:25] = 7'b0000001;    // M extension
            end
            default: begin
                case ($urandom % 4)
                    0: {ins[14:12], ins[6:0]} = {3'd3 + 3'($urandom % 2) * 3'd3, riscv_pkg::LOAD};
                    1: {ins[14:12], ins[6:0]} = {3'd3 + 3'($urandom % 5), riscv_pkg::STORE};
                    2: {ins[14:12], ins[6:0]} = {3'd2 + 3'($urandom % 2), riscv_pkg::BRANCH};
                    default: {ins[14:12], ins[6:0]} = {3'd1 + 3'($urandom % 7), riscv_pkg::JALR};
                endcase
            end
        endcase
        return ins;
    endfunction

    task automatic check_outputs(input expect_t e, input string name);
        check({name, " ex_valid"}, e.valid, ex_valid);
        if (e.valid) begin
            check({name, " ex_illegal"}, e.illegal, ex_illegal);
            check({name, " ex_rf_write_enable"}, e.rf_we, ex_rf_write_enable);
            check({name, " ex_mem_read_enable"}, e.mem_rd, ex_mem_read_enable);
            check({name, " ex_mem_write_enable"}, e.mem_we, ex_mem_write_enable);
            check({name, " ex_jump"}, e.jump, ex_jump);
            check({name, " ex_branch"}, e.branch, ex_branch);
            check({name, " ex_pc"}, e.pc, ex_pc);
            check({name, " ex_imm"}, e.imm, ex_imm);
            check({name, " ex_rd"}, e.rd, ex_rd);
            check({name, " ex_rs1"}, e.rs1, ex_rs1);
            check({name, " ex_rs2"}, e.rs2, ex_rs2);
            check({name, " ex_funct3"}, e.funct3, ex_funct3);
            if (!e.illegal) begin
                check({name, " ex_pc_rs1_sel"}, e.pc_sel, ex_pc_rs1_sel);
                check({name, " ex_imm_rs2_sel"}, e.imm_sel, ex_imm_rs2_sel);
                check({name, " ex_mem_size"}, e.mem_size, 32'(ex_mem_size));
                check({name, " ex_load_unsigned"}, e.load_uns, ex_load_unsigned);
                check({name, " ex_alu_op"}, e.alu_op, 32'(ex_alu_op));
                check({name, " ex_wb_sel"}, e.wb_sel, 32'(ex_wb_sel));
            end
        end
    endtask

    // one cycle per call that checks the previous result before driving the next
    task automatic step(input logic v, input logic [31:0] ins, input logic fl, input string name);
        logic [31:0] p;
        p = 32'($urandom) & 32'hffff_fffc;
        @(posedge clk);
        #2;
        if (pending_live)
            check_outputs(pending, pending_name);
        instr_valid = v;
        instr = ins;
        pc = p;
        flush = fl;
        pending = decode_model(ins, p);
        pending.valid = v && !fl;
        pending_name = name;
        pending_live = 1'b1;
    endtask

    initial begin
        #((NUM_ISSUED * 20 + 100) * 20);
        $display("timeout: the stimulus did not finish before the watchdog expired");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        wait (i_dut.i_id_ex_register.i_decode_stage_asserts.error_count != 0);
        $display("an assertion on the ID/EX register outputs failed");
        $display("TESTS FAILED");
        $fatal(1, "assertion failure");
    end

    initial begin
        logic [31:0] ins;
        void'($urandom(32'hd6115b20));
        instr_valid = 1'b1;    // a jal strobed under reset must not get through
        instr = legal_instr(7);
        pc = '0;
        flush = 1'b0;
        pending_live = 1'b0;
        @(negedge reset);
        instr_valid = 1'b0;
        check("reset ex_valid", 0, ex_valid);
        check("reset ex_rf_write_enable", 0, ex_rf_write_enable);
        check("reset ex_mem_read_enable", 0, ex_mem_read_enable);
        check("reset ex_mem_write_enable", 0, ex_mem_write_enable);
        check("reset ex_jump", 0, ex_jump);
        check("reset ex_branch", 0, ex_branch);

        for (int i = 0; i < NUM_LEGAL; i++)
            step(1'b1, legal_instr($urandom), 1'b0, "legal");

        // LOAD through JALR cover the I, S, B, U and J formats
        for (int r = 0; r < NUM_IMM; r++) begin
            for (int k = 2; k < 9; k++) begin
                for (int s = 0; s < 2; s++) begin
                    ins = legal_instr(k);
                    ins[31] = s[0];
                    step(1'b1, ins, 1'b0, "immediate");
                end
            end
        end

        for (int i = 0; i < NUM_ILLEGAL; i++)
            step(1'b1, illegal_instr(i), 1'b0, "illegal");

        step(1'b1, legal_instr($urandom), 1'b0, "before_flush");
        step(1'b1, legal_instr($urandom), 1'b1, "flush_with_strobe");
        step(1'b1, legal_instr($urandom), 1'b0, "after_flush");
        step(1'b0, legal_instr($urandom), 1'b1, "flush_alone");
        step(1'b1, legal_instr($urandom), 1'b0, "legal");
        step(1'b0, legal_instr($urandom), 1'b0, "gap");
        step(1'b0, 32'd0, 1'b0, "gap");
        step(1'b1, legal_instr($urandom), 1'b0, "after_gap");
        step(1'b0, 32'd0, 1'b0, "drain");

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
rtl/riscv_pkg.sv
rtl/decode_ctrl_if.sv
rtl/control_unit.sv
rtl/imm_gen.sv
rtl/id_ex_register.sv
rtl/decode_stage.sv
testbench/tb_clock_gen.sv
testbench/decode_stage_asserts.sv
testbench/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

export_include_dirs:
  - include

sources:
  - rtl/riscv_pkg.sv
  - rtl/decode_ctrl_if.sv
  - rtl/control_unit.sv
  - rtl/imm_gen.sv
  - rtl/id_ex_register.sv
  - rtl/decode_stage.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/decode_stage_asserts.sv
      - testbench/tb_decode_stage.sv
